//--- Makefile
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_wb_subsys
RTL_TOP    := wb_subsys_top
FILELIST   := wb_subsys_top.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bus_map_pkg.sv
package bus_map_pkg;

  // slave windows
  localparam int NUM_SLAVES = 2;
  localparam int SLV_IDX_W  = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;
  localparam int SLV_CTRL   = 0;
  localparam int SLV_MEM    = 1;

  // entry 0 is the control bank, entry 1 the scratch memory
  localparam logic [NUM_SLAVES-1:0][31:0] SLAVE_BASE  = {32'h0000_1000, 32'h0000_0000};
  localparam logic [NUM_SLAVES-1:0][31:0] SLAVE_LIMIT = {32'h0000_13ff, 32'h0000_00ff};

  // cycles in WAIT before the decoder gives up
  localparam int BUS_TIMEOUT = 10;
  localparam int TMO_W       = $clog2(BUS_TIMEOUT + 1);

  // scratch memory geometry
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = $clog2(MEM_WORDS);

  // control bank byte offsets
  localparam logic [31:0] REG_ID      = 32'h0000_0000;
  localparam logic [31:0] REG_SCRATCH = 32'h0000_0004;
  localparam logic [31:0] REG_WAIT    = 32'h0000_0008;

  localparam logic [31:0] ID_VALUE = 32'h5742_0001;

  // memory wait states programmed through REG_WAIT
  localparam int WAIT_W = 4;

endpackage

//--- bus_timeout.sv
`timescale 1ns/100ps

module bus_timeout import bus_map_pkg::*; (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic run_i,
  output logic expired_o
);

  logic [TMO_W-1:0] count;

  // saturates at the limit, restarts each time run goes low
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || !run_i) begin
      count <= '0;
    end else if (count != TMO_W'(BUS_TIMEOUT)) begin
      count <= count + 1'b1;
    end
  end

  assign expired_o = run_i && (count == TMO_W'(BUS_TIMEOUT));

  // a flag means run has been up for the whole window
  a_expired_in_run: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    expired_o |-> run_i && $past(run_i, BUS_TIMEOUT)
  );

endmodule

//--- tb_wb_subsys.sv
`timescale 1ns/100ps

module tb_wb_subsys import wb_pkg::*, bus_map_pkg::*; ();

  // about 120 transfers of roughly 10 cycles each, with wide margin
  localparam int MAX_CYCLES = 4000;
  localparam int RSP_LIMIT  = 40;
  localparam int MEM_TESTS  = 40;
  localparam logic [9:0][3:0] SEL_LIST = {
    4'h0, 4'ha, 4'h5, 4'hc, 4'h3, 4'h8, 4'h4, 4'h2, 4'h1, 4'hf
  };

  logic    wb_clk;
  logic    wb_rst;
  logic    wbm_cyc;
  logic    wbm_stb;
  wb_req_t wbm_req;
  wb_rsp_t wbm_rsp;

  // expectation for the transfer in flight
  logic        busy;
  logic        exp_ack;
  logic        exp_chk;
  logic [31:0] exp_dat;

  logic [31:0]       rng_state;
  logic [31:0]       scratch_model;
  logic [WAIT_W-1:0] wait_model;
  logic [31:0]       mem_model [MEM_WORDS];
  logic [31:0]       mem_addr [MEM_TESTS];
  int                cycle_cnt;
  int                err_cnt;
  int                xfer_cnt;
  int                test_cnt;
  int                test_bad;

  wb_subsys_top wb_subsys_top_i (
    .wb_clk_i  (wb_clk),
    .wb_rst_i  (wb_rst),
    .wbm_cyc_i (wbm_cyc),
    .wbm_stb_i (wbm_stb),
    .wbm_req_i (wbm_req),
    .wbm_rsp_o (wbm_rsp)
  );

  always #10 wb_clk = ~wb_clk;

  always @(posedge wb_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("run stopped after %0d cycles without reaching the end", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  a_rsp_expected: assert property (
    @(posedge wb_clk) disable iff (wb_rst)
    (wbm_rsp.ack || wbm_rsp.err) |-> busy
  ) else begin
    $display("response on wbm_rsp_o while no transfer was in progress");
    err_cnt++;
  end

  a_rsp_kind: assert property (
    @(posedge wb_clk) disable iff (wb_rst)
    (wbm_rsp.ack || wbm_rsp.err) |-> (wbm_rsp.ack == exp_ack)
  ) else begin
    $display("ERR wbm_rsp_o.ack expected %h got %h", $sampled(exp_ack), $sampled(wbm_rsp.ack));
    err_cnt++;
  end

  a_rsp_data: assert property (
    @(posedge wb_clk) disable iff (wb_rst)
    (wbm_rsp.ack && exp_chk) |-> (wbm_rsp.dat == exp_dat)
  ) else begin
    $display("ERR wbm_rsp_o.dat expected %h got %h", $sampled(exp_dat), $sampled(wbm_rsp.dat));
    err_cnt++;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value = rng_state;
  endtask

  // bytes with sel set come from the new word
  function automatic logic [31:0] byte_merge(logic [31:0] old_v, logic [31:0] new_v,
                                             logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (new_v & mask) | (old_v & ~mask);
  endfunction

  function automatic logic [MEM_AW-1:0] mem_index(logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - SLAVE_BASE[SLV_MEM];
    return offset[MEM_AW+1:2];
  endfunction

  task automatic bus_xfer(input logic wr, input logic [3:0] be, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic want_ack, input logic chk,
                          input logic [31:0] want_dat, output logic got_ack,
                          output logic [31:0] got_dat);
    int   waited;
    logic done;
    waited  = 0;
    done    = 1'b0;
    got_ack = 1'b0;
    got_dat = '0;
    @(posedge wb_clk);
    exp_ack <= want_ack;
    exp_chk <= chk;
    exp_dat <= want_dat;
    busy    <= 1'b1;
    wbm_cyc <= 1'b1;
    wbm_stb <= 1'b1;
    wbm_req <= '{we: wr, sel: be, adr: addr, dat: wdata};
    while (!done && waited < RSP_LIMIT) begin
      @(negedge wb_clk);
      waited++;
      if (wbm_rsp.ack || wbm_rsp.err) begin
        done    = 1'b1;
        got_ack = wbm_rsp.ack;
        got_dat = wbm_rsp.dat;
      end
    end
    @(posedge wb_clk);
    wbm_cyc <= 1'b0;
    wbm_stb <= 1'b0;
    busy    <= 1'b0;
    if (!done) begin
      $display("no response within %0d cycles for address %h", RSP_LIMIT, addr);
      err_cnt++;
    end
    xfer_cnt++;
    @(posedge wb_clk);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata, input logic want_ack);
    logic        got_ack;
    logic [31:0] got_dat;
    bus_xfer(1'b1, be, addr, wdata, want_ack, 1'b0, '0, got_ack, got_dat);
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic want_ack,
                          input logic [31:0] want_dat);
    logic        got_ack;
    logic [31:0] got_dat;
    bus_xfer(1'b0, 4'hf, addr, '0, want_ack, want_ack, want_dat, got_ack, got_dat);
  endtask

  task automatic end_test(input string name, input int mark);
    test_cnt++;
    if (err_cnt == mark) begin
      $display("test %s: ok", name);
    end else begin
      test_bad++;
      $display("test %s: %0d errors", name, err_cnt - mark);
    end
  endtask

  task automatic test_scratch();
    int          mark;
    logic [31:0] r;
    mark = err_cnt;
    for (int i = 0; i < 10; i++) begin
      next_random(r);
      scratch_model = byte_merge(scratch_model, r, SEL_LIST[i]);
      bus_write(SLAVE_BASE[SLV_CTRL] + REG_SCRATCH, SEL_LIST[i], r, 1'b1);
      bus_read(SLAVE_BASE[SLV_CTRL] + REG_SCRATCH, 1'b1, scratch_model);
    end
    end_test("scratch", mark);
  endtask

  task automatic test_id();
    int mark;
    mark = err_cnt;
    bus_read(SLAVE_BASE[SLV_CTRL] + REG_ID, 1'b1, ID_VALUE);
    bus_write(SLAVE_BASE[SLV_CTRL] + REG_ID, 4'hf, 32'h1234_5678, 1'b0);
    // first unused offset in the bank
    bus_read(SLAVE_BASE[SLV_CTRL] + 32'h0000_000c, 1'b0, '0);
    bus_write(SLAVE_BASE[SLV_CTRL] + 32'h0000_000c, 4'hf, 32'h0bad_0bad, 1'b0);
    end_test("id", mark);
  endtask

  task automatic test_memory();
    int          mark;
    logic [31:0] r;
    mark = err_cnt;
    for (int i = 0; i < MEM_TESTS; i++) begin
      next_random(r);
      mem_addr[i] = SLAVE_BASE[SLV_MEM] + (r & 32'h0000_03fc);
      next_random(r);
      mem_model[mem_index(mem_addr[i])] = r;
      bus_write(mem_addr[i], 4'hf, r, 1'b1);
    end
    for (int i = 0; i < MEM_TESTS; i++) begin
      bus_read(mem_addr[i], 1'b1, mem_model[mem_index(mem_addr[i])]);
    end
    end_test("memory", mark);
  endtask

  task automatic test_unmapped();
    int mark;
    mark = err_cnt;
    bus_read(32'h0000_0800, 1'b0, '0);
    bus_write(32'h0000_2000, 4'hf, 32'hdead_beef, 1'b0);
    bus_read(32'h0000_2000, 1'b0, '0);
    end_test("unmapped", mark);
  endtask

  task automatic test_wait_states();
    int          mark;
    logic [31:0] r;
    logic [31:0] addr;
    mark = err_cnt;
    addr = SLAVE_BASE[SLV_MEM];
    wait_model = 4'd2;
    bus_write(SLAVE_BASE[SLV_CTRL] + REG_WAIT, 4'hf, 32'(wait_model), 1'b1);
    bus_read(SLAVE_BASE[SLV_CTRL] + REG_WAIT, 1'b1, 32'(wait_model));
    for (int i = 0; i < 4; i++) begin
      next_random(r);
      addr = SLAVE_BASE[SLV_MEM] + (r & 32'h0000_03fc);
      next_random(r);
      mem_model[mem_index(addr)] = r;
      bus_write(addr, 4'hf, r, 1'b1);
      bus_read(addr, 1'b1, mem_model[mem_index(addr)]);
    end
    // slower than BUS_TIMEOUT, so the decoder gives up
    wait_model = 4'd15;
    bus_write(SLAVE_BASE[SLV_CTRL] + REG_WAIT, 4'hf, 32'(wait_model), 1'b1);
    bus_read(addr, 1'b0, '0);
    // late ack of the timed-out read must not show up here
    bus_read(SLAVE_BASE[SLV_CTRL] + REG_WAIT, 1'b1, 32'(wait_model));
    wait_model = 4'd0;
    bus_write(SLAVE_BASE[SLV_CTRL] + REG_WAIT, 4'hf, 32'(wait_model), 1'b1);
    // memory still holds the last written word
    bus_read(addr, 1'b1, mem_model[mem_index(addr)]);
    end_test("wait", mark);
  endtask

  initial begin
    wb_clk        = 1'b0;
    wb_rst        = 1'b1;
    wbm_cyc       = 1'b0;
    wbm_stb       = 1'b0;
    wbm_req       = '0;
    busy          = 1'b0;
    exp_ack       = 1'b0;
    exp_chk       = 1'b0;
    exp_dat       = '0;
    rng_state     = 32'hda75;
    scratch_model = '0;
    wait_model    = '0;
    cycle_cnt     = 0;
    err_cnt       = 0;
    xfer_cnt      = 0;
    test_cnt      = 0;
    test_bad      = 0;
    repeat (5) @(posedge wb_clk);
    wb_rst <= 1'b0;
    repeat (2) @(posedge wb_clk);

    test_scratch();
    test_id();
    test_memory();
    test_unmapped();
    test_wait_states();

    $display("summary: %0d tests, %0d with errors, %0d transfers, %0d error events",
             test_cnt, test_bad, xfer_cnt, err_cnt);
    if (err_cnt == 0 && test_bad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- wb_ctrl_regs.sv
`timescale 1ns/100ps

module wb_ctrl_regs import wb_pkg::*, bus_map_pkg::*; (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  logic              cyc_i,
  input  wb_req_t           req_i,
  output wb_rsp_t           rsp_o,
  output logic [WAIT_W-1:0] wait_cycles_o
);

  logic [31:0]       scratch_q;
  logic [WAIT_W-1:0] wait_q;
  logic [31:0]       rd_data;

  always_comb begin
    case (req_i.adr)
      REG_ID:      rd_data = ID_VALUE;
      REG_SCRATCH: rd_data = scratch_q;
      REG_WAIT:    rd_data = 32'(wait_q);
      default:     rd_data = '0;
    endcase
  end

  // answers one cycle after the strobe
  always_ff @(posedge wb_clk_i) begin
    rsp_o.dat <= rd_data;
    if (wb_rst_i) begin
      rsp_o.ack <= 1'b0;
      rsp_o.err <= 1'b0;
      scratch_q <= '0;
      wait_q    <= '0;
    end else begin
      rsp_o.ack <= 1'b0;
      rsp_o.err <= 1'b0;
      if (cyc_i) begin
        case (req_i.adr)
          REG_ID: begin
            // read only
            rsp_o.err <= req_i.we;
            rsp_o.ack <= !req_i.we;
          end
          REG_SCRATCH: begin
            if (req_i.we) begin
              for (int b = 0; b < 4; b++) begin
                if (req_i.sel[b]) begin
                  scratch_q[8*b +: 8] <= req_i.dat[8*b +: 8];
                end
              end
            end
            rsp_o.ack <= 1'b1;
          end
          REG_WAIT: begin
            if (req_i.we && req_i.sel[0]) begin
              wait_q <= req_i.dat[WAIT_W-1:0];
            end
            rsp_o.ack <= 1'b1;
          end
          default: begin
            rsp_o.err <= 1'b1;
          end
        endcase
      end
    end
  end

  assign wait_cycles_o = wait_q;

endmodule

//--- wb_pkg.sv
package wb_pkg;

  // request from the master, and from the decoder to each slave
  typedef struct packed {
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_req_t;

  // response from a slave, also used toward the master
  // exactly one of ack and err pulses per request
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
    logic        err;
  } wb_rsp_t;

endpackage

//--- wb_scratch_mem.sv
`timescale 1ns/100ps

module wb_scratch_mem import wb_pkg::*, bus_map_pkg::*; (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  logic              cyc_i,
  input  wb_req_t           req_i,
  input  logic [WAIT_W-1:0] wait_cycles_i,
  output wb_rsp_t           rsp_o
);

  logic [31:0]       mem [MEM_WORDS];
  logic [MEM_AW-1:0] mem_idx;
  logic [31:0]       rd_data;
  logic [WAIT_W-1:0] wait_cnt;
  logic              pending;
  logic              ack_q;

  // word index within the window
  assign mem_idx = req_i.adr[MEM_AW+1:2];

  // read before write, data held until the ack
  always_ff @(posedge wb_clk_i) begin
    if (cyc_i) begin
      rd_data <= mem[mem_idx];
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.sel[b]) begin
            mem[mem_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
          end
        end
      end
    end
  end

  // ack lands wait_cycles+1 after the strobe
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wait_cnt <= '0;
      pending  <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      if (cyc_i) begin
        wait_cnt <= wait_cycles_i;
        pending  <= (wait_cycles_i != '0);
        ack_q    <= (wait_cycles_i == '0);
      end else if (pending) begin
        wait_cnt <= wait_cnt - 1'b1;
        if (wait_cnt == WAIT_W'(1)) begin
          pending <= 1'b0;
          ack_q   <= 1'b1;
        end
      end
    end
  end

  assign rsp_o = '{dat: rd_data, ack: ack_q, err: 1'b0};

  // decoder must not re-strobe before the previous answer
  a_no_overlap: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    cyc_i |-> !pending
  );

endmodule

//--- wb_subsys_top.f
wb_pkg.sv
bus_map_pkg.sv
bus_timeout.sv
wbs_arbiter.sv
wb_ctrl_regs.sv
wb_scratch_mem.sv
wb_subsys_top.sv
tb_wb_subsys.sv

//--- wb_subsys_top.sv
`timescale 1ns/100ps

module wb_subsys_top import wb_pkg::*, bus_map_pkg::*; (
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  logic    wbm_cyc_i,
  input  logic    wbm_stb_i,
  input  wb_req_t wbm_req_i,
  output wb_rsp_t wbm_rsp_o
);

  logic [NUM_SLAVES-1:0]    wbs_cyc;
  wb_req_t                  wbs_req;
  wb_rsp_t [NUM_SLAVES-1:0] wbs_rsp;
  logic                     tmo_run;
  logic                     tmo_expired;
  logic [WAIT_W-1:0]        wait_cycles;

  wbs_arbiter wbs_arbiter_i (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wbm_cyc_i     (wbm_cyc_i),
    .wbm_stb_i     (wbm_stb_i),
    .wbm_req_i     (wbm_req_i),
    .wbm_rsp_o     (wbm_rsp_o),
    .wbs_cyc_o     (wbs_cyc),
    .wbs_req_o     (wbs_req),
    .wbs_rsp_i     (wbs_rsp),
    .tmo_run_o     (tmo_run),
    .tmo_expired_i (tmo_expired)
  );

  bus_timeout bus_timeout_i (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .run_i     (tmo_run),
    .expired_o (tmo_expired)
  );

  // control bank also sets the memory wait states
  wb_ctrl_regs wb_ctrl_regs_i (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .cyc_i         (wbs_cyc[SLV_CTRL]),
    .req_i         (wbs_req),
    .rsp_o         (wbs_rsp[SLV_CTRL]),
    .wait_cycles_o (wait_cycles)
  );

  wb_scratch_mem wb_scratch_mem_i (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .cyc_i         (wbs_cyc[SLV_MEM]),
    .req_i         (wbs_req),
    .wait_cycles_i (wait_cycles),
    .rsp_o         (wbs_rsp[SLV_MEM])
  );

endmodule

//--- wbs_arbiter.sv
`timescale 1ns/100ps

module wbs_arbiter import wb_pkg::*, bus_map_pkg::*; (
  input  logic                     wb_clk_i,
  input  logic                     wb_rst_i,
  input  logic                     wbm_cyc_i,
  input  logic                     wbm_stb_i,
  input  wb_req_t                  wbm_req_i,
  output wb_rsp_t                  wbm_rsp_o,
  output logic [NUM_SLAVES-1:0]    wbs_cyc_o,
  output wb_req_t                  wbs_req_o,
  input  wb_rsp_t [NUM_SLAVES-1:0] wbs_rsp_i,
  output logic                     tmo_run_o,
  input  logic                     tmo_expired_i
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    DRAIN
  } state_t;

  state_t                   state;
  logic                     drain_cnt;
  logic                     wbm_cyc_r;
  logic                     wbm_stb_r;
  wb_req_t                  wbm_req_r;
  wb_rsp_t [NUM_SLAVES-1:0] wbs_rsp_r;
  logic [NUM_SLAVES-1:0]    slv_hit;
  logic [SLV_IDX_W-1:0]     slv_enc;
  logic [SLV_IDX_W-1:0]     active_q;
  logic [31:0]              adr_rebased;
  wb_rsp_t                  slv_rsp;
  logic                     req_valid;
  logic                     dec_err;
  logic                     done_ack;
  logic                     done_err;

  // master input stage
  always_ff @(posedge wb_clk_i) begin
    wbm_req_r <= wbm_req_i;
    if (wb_rst_i) begin
      wbm_cyc_r <= 1'b0;
      wbm_stb_r <= 1'b0;
    end else begin
      wbm_cyc_r <= wbm_cyc_i;
      wbm_stb_r <= wbm_stb_i;
    end
  end

  // slave response stage
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wbs_rsp_r <= '0;
    end else begin
      wbs_rsp_r <= wbs_rsp_i;
    end
  end

  // window compare, then encode and rebase
  always_comb begin
    slv_hit = '0;
    slv_enc = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      slv_hit[i] = (wbm_req_r.adr >= SLAVE_BASE[i]) && (wbm_req_r.adr <= SLAVE_LIMIT[i]);
      if (slv_hit[i]) begin
        slv_enc = SLV_IDX_W'(i);
      end
    end
    adr_rebased = wbm_req_r.adr - SLAVE_BASE[slv_enc];
  end

  assign req_valid = (state == IDLE) && wbm_cyc_r && wbm_stb_r;
  assign dec_err   = req_valid && (slv_hit == '0);

  // only the latched slave may finish the transfer
  assign slv_rsp  = wbs_rsp_r[active_q];
  assign done_ack = (state == WAIT) && slv_rsp.ack;
  assign done_err = (state == WAIT) && !slv_rsp.ack && (slv_rsp.err || tmo_expired_i);

  assign tmo_run_o = (state == WAIT);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state     <= IDLE;
      drain_cnt <= 1'b0;
      wbs_cyc_o <= '0;
      active_q  <= '0;
    end else begin
      // strobe is a single-cycle pulse
      wbs_cyc_o <= '0;
      case (state)
        IDLE: begin
          if (req_valid) begin
            drain_cnt <= 1'b0;
            if (dec_err) begin
              state <= DRAIN;
            end else begin
              wbs_cyc_o <= slv_hit;
              active_q  <= slv_enc;
              state     <= WAIT;
            end
          end
        end
        WAIT: begin
          if (done_ack || done_err) begin
            drain_cnt <= 1'b0;
            state     <= DRAIN;
          end
        end
        DRAIN: begin
          // stale master strobe still sits in the input stage
          if (drain_cnt) begin
            state <= IDLE;
          end else begin
            drain_cnt <= 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // shared request to the slaves, held until the next strobe
  always_ff @(posedge wb_clk_i) begin
    if (req_valid && !dec_err) begin
      wbs_req_o.we  <= wbm_req_r.we;
      wbs_req_o.sel <= wbm_req_r.sel;
      wbs_req_o.adr <= adr_rebased;
      wbs_req_o.dat <= wbm_req_r.dat;
    end
  end

  // master output stage
  always_ff @(posedge wb_clk_i) begin
    wbm_rsp_o.dat <= slv_rsp.dat;
    if (wb_rst_i) begin
      wbm_rsp_o.ack <= 1'b0;
      wbm_rsp_o.err <= 1'b0;
    end else begin
      wbm_rsp_o.ack <= done_ack;
      wbm_rsp_o.err <= dec_err || done_err;
    end
  end

  a_cyc_onehot: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0(wbs_cyc_o)
  );

  a_rsp_excl: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wbm_rsp_o.ack && wbm_rsp_o.err)
  );

endmodule
